// ==== hdl/plic_axil_slave.sv ====
// AXI4-Lite slave front end
`timescale 1ns/1ps

module plic_axil_slave import plic_pkg::*; (
    input  logic              i_clk,
    input  logic              i_nrst,
    input  logic              i_awvalid,
    output logic              o_awready,
    input  addr_t             i_awaddr,
    input  logic              i_wvalid,
    output logic              o_wready,
    input  data_t             i_wdata,
    input  logic [STRB_W-1:0] i_wstrb,
    output logic              o_bvalid,
    input  logic              i_bready,
    output resp_t             o_bresp,
    input  logic              i_arvalid,
    output logic              o_arready,
    input  addr_t             i_araddr,
    output logic              o_rvalid,
    input  logic              i_rready,
    output data_t             o_rdata,
    output resp_t             o_rresp,
    plic_reg_if.master        bus
);

    typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_RESP} state_t;

    state_t            state_q;
    state_t            state_d;
    logic              ready_q;        // idle and able to take a transaction
    logic              is_write_q;
    logic              bvalid_q;
    logic              rvalid_q;
    resp_t             resp_q;
    addr_t             addr_q;
    data_t             wdata_q;
    logic [STRB_W-1:0] wstrb_q;
    data_t             rdata_q;
    logic              take_rd;
    logic              take_wr;
    logic              resp_done;

    // reads win when both arrive together
    assign take_rd   = ready_q && i_arvalid;
    assign take_wr   = ready_q && i_awvalid && i_wvalid && !i_arvalid;
    assign resp_done = (bvalid_q && i_bready) || (rvalid_q && i_rready);

    // AW and W only handshake as a pair
    assign o_arready = ready_q;
    assign o_awready = ready_q && i_wvalid && !i_arvalid;
    assign o_wready  = ready_q && i_awvalid && !i_arvalid;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: if (take_rd || take_wr) state_d = ST_REQ;
            ST_REQ:  if (bus.req_ready) state_d = ST_RESP;
            ST_RESP: if (resp_done) state_d = ST_IDLE;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q    <= ST_IDLE;
            ready_q    <= 1'b0;
            is_write_q <= 1'b0;
            bvalid_q   <= 1'b0;
            rvalid_q   <= 1'b0;
            resp_q     <= RESP_OKAY;
        end else begin
            state_q <= state_d;
            ready_q <= (state_d == ST_IDLE);
            if (take_rd || take_wr) is_write_q <= take_wr;
            if (state_q == ST_RESP && bus.resp_valid) begin
                bvalid_q <= is_write_q;
                rvalid_q <= !is_write_q;
                resp_q   <= bus.resp_err ? RESP_SLVERR : RESP_OKAY;
            end else begin
                if (i_bready) bvalid_q <= 1'b0;
                if (i_rready) rvalid_q <= 1'b0;
            end
        end
    end

    // transaction payload
    always_ff @(posedge i_clk) begin
        if (take_rd || take_wr) begin
            addr_q  <= take_rd ? i_araddr : i_awaddr;
            wdata_q <= i_wdata;
            wstrb_q <= i_wstrb;
        end
        if (state_q == ST_RESP && bus.resp_valid) rdata_q <= bus.resp_rdata;
    end

    assign bus.req_valid = (state_q == ST_REQ);
    assign bus.req_write = is_write_q;
    assign bus.req_addr  = addr_q;
    assign bus.req_wdata = wdata_q;
    assign bus.req_wstrb = wstrb_q;

    assign o_bvalid = bvalid_q;
    assign o_bresp  = resp_q;
    assign o_rvalid = rvalid_q;
    assign o_rdata  = rdata_q;
    assign o_rresp  = resp_q;

    // a response stays up until the master takes it
    a_bvalid_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_bvalid && !i_bready |=> o_bvalid);
    a_rvalid_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_rvalid && !i_rready |=> o_rvalid);

endmodule

// ==== hdl/plic_ctrl.sv ====
// PLIC register file and claim control
`timescale 1ns/1ps

module plic_ctrl import plic_pkg::*; (
    input  logic                          i_clk,
    input  logic                          i_nrst,
    plic_reg_if.target                    bus,
    input  logic [NSRC-1:0]               i_pending,
    input  src_id_t [NCTX-1:0]            i_best_id,
    output prio_t [NSRC-1:0]              o_prio,
    output logic [NCTX-1:0][NSRC-1:0]     o_enable,
    output prio_t [NCTX-1:0]              o_threshold,
    output logic                          o_claim,
    output src_id_t                       o_claim_id,
    output logic                          o_complete,
    output src_id_t                       o_complete_id
);

    prio_t [NSRC-1:0]          prio_q;       // entry 0 stays zero
    logic [NCTX-1:0][NSRC-1:0] enable_q;
    prio_t [NCTX-1:0]          threshold_q;
    logic                      resp_valid_q;
    logic                      resp_err_q;
    data_t                     rdata_q;

    addr_t             addr;
    logic              fire;
    logic              wr;
    logic              hit_prio;
    logic              hit_pend;
    logic              hit_en;
    logic              hit_thr;
    logic              hit_claim;
    logic              hit_ctx;
    logic [CTX_W-1:0]  en_ctx;
    logic [CTX_W-1:0]  cc_ctx;
    logic [ID_W-1:0]   src_idx;
    logic [NSRC-1:0]   en_next;
    data_t             rdata_c;
    logic              err_c;

    assign bus.req_ready = 1'b1;   // every request is served in one cycle
    assign fire          = bus.req_valid && bus.req_ready;
    assign wr            = fire && bus.req_write;
    assign addr          = bus.req_addr;

    // address decode ignores the low two bits
    assign src_idx  = addr[6:2];
    assign en_ctx   = addr[7 +: CTX_W];
    assign cc_ctx   = addr[12 +: CTX_W];
    assign hit_prio = (addr[ADDR_W-1:7] == PRIO_BASE[ADDR_W-1:7]);
    assign hit_pend = (addr[ADDR_W-1:2] == PEND_BASE[ADDR_W-1:2]);
    assign hit_en   = (addr[ADDR_W-1:12] == EN_BASE[ADDR_W-1:12])
                      && (addr[6:2] == '0) && (addr[11:7] < NCTX);
    assign hit_ctx  = (addr[ADDR_W-1:21] == CTX_BASE[ADDR_W-1:21])
                      && (addr[20:12] < NCTX) && (addr[11:3] == '0);
    assign hit_thr   = hit_ctx && !addr[2];
    assign hit_claim = hit_ctx && addr[2];

    always_comb begin
        rdata_c = '0;
        err_c   = 1'b0;
        if (hit_prio)       rdata_c[PRIO_W-1:0] = prio_q[src_idx];
        else if (hit_pend)  rdata_c[NSRC-1:0]   = i_pending;
        else if (hit_en)    rdata_c[NSRC-1:0]   = enable_q[en_ctx];
        else if (hit_thr)   rdata_c[PRIO_W-1:0] = threshold_q[cc_ctx];
        else if (hit_claim) rdata_c[ID_W-1:0]   = i_best_id[cc_ctx];
        else                err_c               = 1'b1;   // outside the map
    end

    // byte-wise merge into the enable word
    always_comb begin
        en_next = enable_q[en_ctx];
        for (int b = 0; b < STRB_W; b++) begin
            if (bus.req_wstrb[b]) en_next[8*b +: 8] = bus.req_wdata[8*b +: 8];
        end
        en_next[0] = 1'b0;   // ID 0 can never be enabled
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            prio_q      <= '0;
            enable_q    <= '0;
            threshold_q <= '0;
        end else begin
            if (wr && hit_prio && src_idx != '0 && bus.req_wstrb[0])
                prio_q[src_idx] <= bus.req_wdata[PRIO_W-1:0];
            if (wr && hit_en)
                enable_q[en_ctx] <= en_next;
            if (wr && hit_thr && bus.req_wstrb[0])
                threshold_q[cc_ctx] <= bus.req_wdata[PRIO_W-1:0];
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            resp_valid_q <= 1'b0;
            resp_err_q   <= 1'b0;
        end else begin
            resp_valid_q <= fire;
            resp_err_q   <= fire && err_c;
        end
    end

    always_ff @(posedge i_clk) begin
        if (fire) rdata_q <= rdata_c;
    end

    // claim on read and complete on write happen in the request cycle
    assign o_claim       = fire && !bus.req_write && hit_claim && (i_best_id[cc_ctx] != '0);
    assign o_claim_id    = i_best_id[cc_ctx];
    assign o_complete    = wr && hit_claim && bus.req_wstrb[0];
    assign o_complete_id = bus.req_wdata[ID_W-1:0];

    assign bus.resp_valid = resp_valid_q;
    assign bus.resp_rdata = rdata_q;
    assign bus.resp_err   = resp_err_q;

    assign o_prio      = prio_q;
    assign o_enable    = enable_q;
    assign o_threshold = threshold_q;

    // the slave waits for each response before it sends the next request
    a_one_outstanding: assert property (@(posedge i_clk) disable iff (!i_nrst)
        bus.resp_valid |-> !bus.req_valid);

endmodule

// ==== hdl/plic_gateway.sv ====
// PLIC interrupt gateways
`timescale 1ns/1ps

module plic_gateway import plic_pkg::*; (
    input  logic             i_clk,
    input  logic             i_nrst,
    input  logic [NSRC-1:0]  i_irq,
    input  prio_t [NSRC-1:0] i_prio,
    input  logic             i_claim,
    input  src_id_t          i_claim_id,
    input  logic             i_complete,
    input  src_id_t          i_complete_id,
    output logic [NSRC-1:0]  o_pending
);

    logic [NSRC-1:1] pending_q;
    logic [NSRC-1:1] inflight_q;   // claimed, waiting for complete

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            pending_q  <= '0;
            inflight_q <= '0;
        end else begin
            for (int i = 1; i < NSRC; i++) begin
                if (i_claim && i_claim_id == src_id_t'(i)) begin
                    pending_q[i]  <= 1'b0;
                    inflight_q[i] <= 1'b1;
                end else begin
                    // level request latched unless masked by priority 0 or in flight
                    if (i_irq[i] && i_prio[i] != '0 && !inflight_q[i])
                        pending_q[i] <= 1'b1;
                    if (i_complete && i_complete_id == src_id_t'(i) && inflight_q[i])
                        inflight_q[i] <= 1'b0;
                end
            end
        end
    end

    assign o_pending = {pending_q, 1'b0};   // ID 0 never pends

    // the arbiter only offers pending, nonzero IDs for claim
    a_claim_pending: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_claim |-> (i_claim_id != '0) && o_pending[i_claim_id]);

endmodule

// ==== hdl/plic_pkg.sv ====
// PLIC shared definitions
package plic_pkg;

    // sizes
    localparam int NSRC   = 32;             // source lines, ID 0 reserved
    localparam int NCTX   = 2;              // interrupt targets
    localparam int CTX_W  = $clog2(NCTX);   // context index width
    localparam int PRIO_W = 4;
    localparam int ID_W   = 5;
    localparam int ADDR_W = 22;
    localparam int DATA_W = 32;
    localparam int STRB_W = 4;

    typedef logic [PRIO_W-1:0] prio_t;
    typedef logic [ID_W-1:0]   src_id_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [1:0]        resp_t;

    // AXI response codes
    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_SLVERR = 2'd2;

    // register map
    localparam addr_t PRIO_BASE = 22'h000000;   // 4 bytes per source
    localparam addr_t PEND_BASE = 22'h001000;   // single pending word
    localparam addr_t EN_BASE   = 22'h002000;   // 0x80 per context
    localparam addr_t CTX_BASE  = 22'h200000;   // 0x1000 per context, claim at +4

endpackage

// ==== hdl/plic_reg_if.sv ====
// PLIC register bus
`timescale 1ns/1ps

interface plic_reg_if import plic_pkg::*; ();

    logic              req_valid;
    logic              req_ready;
    logic              req_write;
    addr_t             req_addr;
    data_t             req_wdata;
    logic [STRB_W-1:0] req_wstrb;

    logic              resp_valid;
    data_t             resp_rdata;
    logic              resp_err;

    // bus side, issues one request at a time
    modport master (
        output req_valid, req_write, req_addr, req_wdata, req_wstrb,
        input  req_ready, resp_valid, resp_rdata, resp_err
    );

    // register file side
    modport target (
        input  req_valid, req_write, req_addr, req_wdata, req_wstrb,
        output req_ready, resp_valid, resp_rdata, resp_err
    );

endinterface

// ==== hdl/plic_target.sv ====
// PLIC per-context arbiter
`timescale 1ns/1ps

module plic_target import plic_pkg::*; (
    input  logic             i_clk,
    input  logic             i_nrst,
    input  logic [NSRC-1:0]  i_pending,
    input  prio_t [NSRC-1:0] i_prio,
    input  logic [NSRC-1:0]  i_enable,
    input  prio_t            i_threshold,
    output src_id_t          o_best_id,
    output logic             o_irq
);

    src_id_t best_id;
    prio_t   best_prio;
    logic    irq_q;

    // ascending scan with strict compare keeps the lowest ID on a tie,
    // starting from the threshold drops anything at or below it
    always_comb begin
        best_id   = '0;
        best_prio = i_threshold;
        for (int i = 1; i < NSRC; i++) begin
            if (i_pending[i] && i_enable[i] && (i_prio[i] > best_prio)) begin
                best_id   = src_id_t'(i);
                best_prio = i_prio[i];
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            irq_q <= 1'b0;
        end else begin
            irq_q <= (best_id != '0);
        end
    end

    assign o_best_id = best_id;
    assign o_irq     = irq_q;

endmodule

// ==== hdl/plic_top.sv ====
// PLIC top level
`timescale 1ns/1ps

module plic_top import plic_pkg::*; (
    input  logic              i_clk,
    input  logic              i_nrst,
    input  logic              i_awvalid,
    output logic              o_awready,
    input  addr_t             i_awaddr,
    input  logic              i_wvalid,
    output logic              o_wready,
    input  data_t             i_wdata,
    input  logic [STRB_W-1:0] i_wstrb,
    output logic              o_bvalid,
    input  logic              i_bready,
    output resp_t             o_bresp,
    input  logic              i_arvalid,
    output logic              o_arready,
    input  addr_t             i_araddr,
    output logic              o_rvalid,
    input  logic              i_rready,
    output data_t             o_rdata,
    output resp_t             o_rresp,
    input  logic [NSRC-1:0]   i_irq,
    output logic [NCTX-1:0]   o_irq
);

    prio_t [NSRC-1:0]          prio;
    logic [NCTX-1:0][NSRC-1:0] enable;
    prio_t [NCTX-1:0]          threshold;
    src_id_t [NCTX-1:0]        best_id;
    logic [NSRC-1:0]           pending;
    logic                      claim;
    src_id_t                   claim_id;
    logic                      complete;
    src_id_t                   complete_id;

    plic_reg_if reg_bus ();

    plic_axil_slave u_slave (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_awvalid (i_awvalid),
        .o_awready (o_awready),
        .i_awaddr  (i_awaddr),
        .i_wvalid  (i_wvalid),
        .o_wready  (o_wready),
        .i_wdata   (i_wdata),
        .i_wstrb   (i_wstrb),
        .o_bvalid  (o_bvalid),
        .i_bready  (i_bready),
        .o_bresp   (o_bresp),
        .i_arvalid (i_arvalid),
        .o_arready (o_arready),
        .i_araddr  (i_araddr),
        .o_rvalid  (o_rvalid),
        .i_rready  (i_rready),
        .o_rdata   (o_rdata),
        .o_rresp   (o_rresp),
        .bus       (reg_bus.master)
    );

    plic_ctrl u_ctrl (
        .i_clk         (i_clk),
        .i_nrst        (i_nrst),
        .bus           (reg_bus.target),
        .i_pending     (pending),
        .i_best_id     (best_id),
        .o_prio        (prio),
        .o_enable      (enable),
        .o_threshold   (threshold),
        .o_claim       (claim),
        .o_claim_id    (claim_id),
        .o_complete    (complete),
        .o_complete_id (complete_id)
    );

    plic_gateway u_gateway (
        .i_clk         (i_clk),
        .i_nrst        (i_nrst),
        .i_irq         (i_irq),
        .i_prio        (prio),
        .i_claim       (claim),
        .i_claim_id    (claim_id),
        .i_complete    (complete),
        .i_complete_id (complete_id),
        .o_pending     (pending)
    );

    // one arbiter per context
    for (genvar c = 0; c < NCTX; c++) begin : g_target
        plic_target u_target (
            .i_clk       (i_clk),
            .i_nrst      (i_nrst),
            .i_pending   (pending),
            .i_prio      (prio),
            .i_enable    (enable[c]),
            .i_threshold (threshold[c]),
            .o_best_id   (best_id[c]),
            .o_irq       (o_irq[c])
        );
    end

endmodule

// ==== test/plic_tb.sv ====
// PLIC testbench
`timescale 1ns/1ps

module plic_tb import plic_pkg::*; ();

    typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_IRQ, OP_WAIT, OP_CHK_IRQ} op_t;

    typedef struct packed {
        op_t               op;
        addr_t             addr;
        data_t             data;    // write data, expected read data, irq lines or irq vector
        logic [STRB_W-1:0] strb;
        resp_t             resp;
        logic [7:0]        count;
    } step_t;

    localparam addr_t EN0  = EN_BASE;
    localparam addr_t EN1  = EN_BASE + 22'h80;
    localparam addr_t THR0 = CTX_BASE;
    localparam addr_t THR1 = CTX_BASE + 22'h1000;
    localparam addr_t CLM0 = THR0 + 22'h4;
    localparam addr_t CLM1 = THR1 + 22'h4;
    localparam int STEP_CYCLES = 40;      // worst case for one AXI transaction with back-pressure
    localparam int MARGIN      = 200;

    logic              i_clk;
    logic              i_nrst;
    logic              i_awvalid;
    logic              o_awready;
    addr_t             i_awaddr;
    logic              i_wvalid;
    logic              o_wready;
    data_t             i_wdata;
    logic [STRB_W-1:0] i_wstrb;
    logic              o_bvalid;
    logic              i_bready;
    resp_t             o_bresp;
    logic              i_arvalid;
    logic              o_arready;
    addr_t             i_araddr;
    logic              o_rvalid;
    logic              i_rready;
    data_t             o_rdata;
    resp_t             o_rresp;
    logic [NSRC-1:0]   i_irq;
    logic [NCTX-1:0]   o_irq;

    step_t       steps[$];
    bit          table_built = 1'b0;
    int unsigned lcg_state   = 32'h004fbd15;

    plic_top DUT (.*);

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    function automatic int unsigned next_random(input int unsigned range);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return (lcg_state >> 16) % range;
    endfunction

    // reference arbiter, scans priority levels from the top down
    function automatic src_id_t arbitrate(input logic [NSRC-1:0] pend, input logic [NSRC-1:0] en,
                                          input prio_t [NSRC-1:0] prio, input prio_t thr);
        for (int lvl = (1 << PRIO_W) - 1; lvl > thr; lvl--) begin
            for (int id = 1; id < NSRC; id++) begin
                if (pend[id] && en[id] && prio[id] == lvl) return src_id_t'(id);
            end
        end
        return '0;
    endfunction

    // table entries
    task automatic write_reg(input addr_t a, input data_t d, input logic [STRB_W-1:0] s = 4'hf,
                             input resp_t r = RESP_OKAY);
        steps.push_back('{OP_WRITE, a, d, s, r, 8'd0});
    endtask

    task automatic read_reg(input addr_t a, input data_t d, input resp_t r = RESP_OKAY);
        steps.push_back('{OP_READ, a, d, 4'h0, r, 8'd0});
    endtask

    task automatic set_lines(input data_t lines);
        steps.push_back('{OP_IRQ, addr_t'(0), lines, 4'h0, RESP_OKAY, 8'd0});
    endtask

    task automatic idle_cycles(input int n);
        steps.push_back('{OP_WAIT, addr_t'(0), data_t'(0), 4'h0, RESP_OKAY, 8'(n)});
    endtask

    task automatic expect_irq(input logic [NCTX-1:0] v);
        steps.push_back('{OP_CHK_IRQ, addr_t'(0), data_t'(v), 4'h0, RESP_OKAY, 8'd0});
    endtask

    task automatic stop_on_error(input string msg);
        $display("FAILED at %0t ns: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_data(input data_t got, input data_t exp, input string what);
        if (got !== exp) stop_on_error($sformatf("%s data %h, expected %h", what, got, exp));
    endtask

    task automatic check_resp(input resp_t got, input resp_t exp, input string what);
        if (got !== exp) stop_on_error($sformatf("%s resp %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_irq(input logic [NCTX-1:0] got, input logic [NCTX-1:0] exp,
                             input string what);
        if (got !== exp) stop_on_error($sformatf("%s o_irq %b, expected %b", what, got, exp));
    endtask

    // outputs sampled at the rising edge see the values from before the edge
    task automatic axi_write(input addr_t a, input data_t d, input logic [STRB_W-1:0] s,
                             output resp_t r);
        int delay;
        @(negedge i_clk);
        i_awvalid = 1'b1;
        i_wvalid  = 1'b1;
        i_awaddr  = a;
        i_wdata   = d;
        i_wstrb   = s;
        do @(posedge i_clk); while (!(o_awready && o_wready));
        @(negedge i_clk);
        i_awvalid = 1'b0;
        i_wvalid  = 1'b0;
        delay = next_random(4);
        repeat (delay) @(negedge i_clk);   // hold bready low for a while
        i_bready = 1'b1;
        do @(posedge i_clk); while (!o_bvalid);
        r = o_bresp;
        @(negedge i_clk);
        i_bready = 1'b0;
    endtask

    task automatic axi_read(input addr_t a, output data_t d, output resp_t r);
        int delay;
        @(negedge i_clk);
        i_arvalid = 1'b1;
        i_araddr  = a;
        do @(posedge i_clk); while (!o_arready);
        @(negedge i_clk);
        i_arvalid = 1'b0;
        delay = next_random(4);
        repeat (delay) @(negedge i_clk);
        i_rready = 1'b1;
        do @(posedge i_clk); while (!o_rvalid);
        d = o_rdata;
        r = o_rresp;
        @(negedge i_clk);
        i_rready = 1'b0;
    endtask

    initial begin
        wait (table_built);
        repeat (steps.size() * STEP_CYCLES + MARGIN) @(posedge i_clk);
        $display("timeout: the run did not finish within %0d cycles",
                 steps.size() * STEP_CYCLES + MARGIN);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        step_t            st;
        resp_t            resp;
        data_t            rdata;
        prio_t [NSRC-1:0] mprio;
        logic [NSRC-1:0]  mpend;
        logic [NSRC-1:0]  men;
        src_id_t          best;
        src_id_t          claimed[$];

        i_nrst    = 1'b0;
        i_awvalid = 1'b0;
        i_awaddr  = '0;
        i_wvalid  = 1'b0;
        i_wdata   = '0;
        i_wstrb   = '0;
        i_bready  = 1'b0;
        i_arvalid = 1'b0;
        i_araddr  = '0;
        i_rready  = 1'b0;
        i_irq     = '0;

        // register readback and strobes
        write_reg(PRIO_BASE + 22'd20, 32'h3);
        read_reg(PRIO_BASE + 22'd20, 32'h3);
        write_reg(PRIO_BASE + 22'd20, 32'hffff_fff7, 4'b1110);   // byte 0 masked
        read_reg(PRIO_BASE + 22'd20, 32'h3);
        write_reg(PRIO_BASE, 32'h7);
        read_reg(PRIO_BASE, 32'h0);
        write_reg(PRIO_BASE + 22'd124, 32'ha5);
        read_reg(PRIO_BASE + 22'd124, 32'h5);
        write_reg(EN0, 32'hffff_ffff, 4'b0101);
        read_reg(EN0, 32'h00ff_00fe);
        write_reg(EN0, 32'h0);
        read_reg(EN0, 32'h0);
        write_reg(THR1, 32'h2a);
        read_reg(THR1, 32'ha);
        write_reg(THR1, 32'h0, 4'b0000);
        read_reg(THR1, 32'ha);
        write_reg(THR1, 32'h0);
        write_reg(EN1, 32'h1);
        read_reg(EN1, 32'h0);

        // unmapped addresses and context 2
        write_reg(22'h003000, 32'h1, 4'hf, RESP_SLVERR);
        read_reg(22'h003000, 32'h0, RESP_SLVERR);
        write_reg(EN_BASE + 22'h100, 32'hffff_ffff, 4'hf, RESP_SLVERR);
        read_reg(EN_BASE + 22'h100, 32'h0, RESP_SLVERR);
        write_reg(CTX_BASE + 22'h2000, 32'h5, 4'hf, RESP_SLVERR);
        read_reg(CTX_BASE + 22'h2000, 32'h0, RESP_SLVERR);
        read_reg(CTX_BASE + 22'h2004, 32'h0, RESP_SLVERR);
        write_reg(CTX_BASE + 22'h8, 32'h5, 4'hf, RESP_SLVERR);
        read_reg(EN0, 32'h0);
        read_reg(THR0, 32'h0);
        read_reg(PRIO_BASE + 22'd20, 32'h3);

        // pending, threshold and a priority 0 source
        write_reg(PRIO_BASE + 22'd12, 32'h2);
        write_reg(EN0, 32'h8);
        write_reg(THR0, 32'h1);
        set_lines(32'h88);                  // source 7 has priority 0
        idle_cycles(3);
        read_reg(PEND_BASE, 32'h8);
        expect_irq(2'b01);
        write_reg(THR0, 32'h2);
        idle_cycles(2);
        expect_irq(2'b00);
        write_reg(THR0, 32'h1);
        idle_cycles(2);
        expect_irq(2'b01);

        // claim, in flight, complete
        read_reg(CLM0, 32'd3);
        read_reg(PEND_BASE, 32'h0);
        idle_cycles(2);
        expect_irq(2'b00);
        read_reg(CLM0, 32'd0);
        write_reg(CLM0, 32'd3);
        idle_cycles(2);
        read_reg(PEND_BASE, 32'h8);         // request still high
        expect_irq(2'b01);
        set_lines(32'h0);
        read_reg(CLM0, 32'd3);
        write_reg(CLM0, 32'd3);
        read_reg(PEND_BASE, 32'h0);

        // priority order with a tie
        write_reg(PRIO_BASE + 22'd36, 32'h4);
        write_reg(PRIO_BASE + 22'd48, 32'h6);
        write_reg(PRIO_BASE + 22'd80, 32'h6);
        write_reg(EN0, 32'h0010_1208);
        set_lines(32'h0010_1208);
        idle_cycles(3);
        read_reg(CLM0, 32'd12);
        read_reg(CLM0, 32'd20);
        read_reg(CLM0, 32'd9);
        read_reg(CLM0, 32'd3);
        read_reg(CLM0, 32'd0);
        set_lines(32'h0);
        write_reg(CLM0, 32'd12);
        write_reg(CLM0, 32'd20);
        write_reg(CLM0, 32'd9);
        write_reg(CLM0, 32'd3);
        read_reg(PEND_BASE, 32'h0);

        // context routing
        write_reg(EN0, 32'h200);
        write_reg(EN1, 32'h1000);
        set_lines(32'h200);
        idle_cycles(3);
        expect_irq(2'b01);
        read_reg(CLM1, 32'd0);
        read_reg(CLM0, 32'd9);
        set_lines(32'h0);
        write_reg(CLM0, 32'd9);
        set_lines(32'h1000);
        idle_cycles(3);
        expect_irq(2'b10);
        read_reg(CLM0, 32'd0);
        read_reg(CLM1, 32'd12);
        set_lines(32'h0);
        idle_cycles(2);
        expect_irq(2'b00);
        write_reg(CLM1, 32'd12);
        read_reg(PEND_BASE, 32'h0);

        // random priorities against the reference arbiter
        men   = 32'hffff_fffe;
        mprio = '0;
        for (int i = 1; i < NSRC; i++) begin
            mprio[i] = prio_t'(next_random(16));
            write_reg(PRIO_BASE + addr_t'(4 * i), data_t'(mprio[i]));
        end
        write_reg(EN0, men);
        write_reg(EN1, 32'h0);
        write_reg(THR0, 32'h2);
        set_lines(32'hffff_fffe);
        idle_cycles(3);
        mpend = '0;
        for (int i = 1; i < NSRC; i++) begin
            mpend[i] = (mprio[i] != '0);
        end
        do begin
            best = arbitrate(mpend, men, mprio, 4'd2);
            read_reg(CLM0, data_t'(best));
            if (best != '0) begin
                mpend[best] = 1'b0;
                claimed.push_back(best);
            end
        end while (best != '0);
        set_lines(32'h0);
        idle_cycles(3);
        expect_irq(2'b00);                  // leftovers sit at or below the threshold
        read_reg(PEND_BASE, mpend);
        foreach (claimed[k]) write_reg(CLM0, data_t'(claimed[k]));
        read_reg(PEND_BASE, mpend);
        table_built = 1'b1;

        repeat (8) @(posedge i_clk);
        @(negedge i_clk);
        i_nrst = 1'b1;

        foreach (steps[i]) begin
            st = steps[i];
            case (st.op)
                OP_WRITE: begin
                    axi_write(st.addr, st.data, st.strb, resp);
                    check_resp(resp, st.resp, $sformatf("step %0d write %h", i, st.addr));
                end
                OP_READ: begin
                    axi_read(st.addr, rdata, resp);
                    check_resp(resp, st.resp, $sformatf("step %0d read %h", i, st.addr));
                    check_data(rdata, st.data, $sformatf("step %0d read %h", i, st.addr));
                end
                OP_IRQ: begin
                    @(negedge i_clk);
                    i_irq = st.data;
                end
                OP_WAIT: repeat (st.count) @(negedge i_clk);
                OP_CHK_IRQ: begin
                    @(posedge i_clk);
                    check_irq(o_irq, st.data[NCTX-1:0], $sformatf("step %0d", i));
                end
                default: stop_on_error($sformatf("step %0d has an unknown operation", i));
            endcase
        end

        $display("Test passed");
        $finish;
    end

endmodule

// ==== vlog.f ====
hdl/plic_pkg.sv
hdl/plic_reg_if.sv
hdl/plic_axil_slave.sv
hdl/plic_ctrl.sv
hdl/plic_gateway.sv
hdl/plic_target.sv
hdl/plic_top.sv
test/plic_tb.sv
